// File: logic/soc_pkg.sv
// Shared widths, address map and region type for the memory fabric, imported by the RTL
`default_nettype none

package soc_pkg;

  // ----------------------------------------------------------
  // Bus widths
  // ----------------------------------------------------------
  localparam int unsigned AddrWidth  = 32;
  localparam int unsigned DataWidth  = 64;
  localparam int unsigned StrbWidth  = DataWidth / 8;

  // Byte select bits below the word index
  localparam int unsigned WordOffset = 3;

  // ----------------------------------------------------------
  // Address map
  // ----------------------------------------------------------

  // Boot ROM, 4 KiB
  localparam logic [AddrWidth-1:0] RomBase  = 32'h0001_0000;
  localparam int unsigned          RomWords = 512;

  // Upper half of every ROM word
  localparam logic [31:0]          RomTag   = 32'hB007_0000;

  // SRAM, length set by the top level word count
  localparam logic [AddrWidth-1:0] SramBase = 32'h8000_0000;

  // ----------------------------------------------------------
  // Target region of a request
  // ----------------------------------------------------------
  typedef enum logic [1:0] {
    REGION_ROM,
    REGION_SRAM,
    REGION_ERR
  } region_e;

endpackage : soc_pkg

`default_nettype wire

// File: logic/reset_sync.sv
// Reset generator for the fabric, merging power-on reset with the non-debug reset
`timescale 1ns/1ps
`default_nettype none

module reset_sync (
  input  logic clk_i,
  input  logic rst_ni,
  input  logic ndmreset_i,
  output logic sys_rst_no
);

  // Either source pulls the fabric into reset
  logic       rst_comb_n;
  logic [1:0] sync_q;

  assign rst_comb_n = rst_ni & ~ndmreset_i;

  // Async assert, release after two edges
  always_ff @(posedge clk_i or negedge rst_comb_n) begin
    if (!rst_comb_n) begin
      sync_q <= 2'b00;
    end else begin
      sync_q <= {sync_q[0], 1'b1};
    end
  end

  assign sys_rst_no = sync_q[1];

endmodule : reset_sync

`default_nettype wire

// File: logic/addr_decode.sv
// Request decoder that maps each byte address to ROM, SRAM or the error responder
`timescale 1ns/1ps
`default_nettype none

module addr_decode import soc_pkg::*; #(
  parameter int unsigned NumWords = 1024
) (
  input  logic                          req_i,
  input  logic                          we_i,
  input  logic [AddrWidth-1:0]          addr_i,
  output region_e                       region_o,
  output logic                          rom_req_o,
  output logic                          sram_req_o,
  output logic [AddrWidth-WordOffset-1:0] word_idx_o,
  output logic                          err_o
);

  // Region sizes in bytes
  localparam logic [AddrWidth-1:0] RomBytes  = AddrWidth'(RomWords * StrbWidth);
  localparam logic [AddrWidth-1:0] SramBytes = AddrWidth'(NumWords * StrbWidth);

  logic [AddrWidth-1:0] rom_off;
  logic [AddrWidth-1:0] sram_off;
  logic                 in_rom;
  logic                 in_sram;

  // Offsets into each region
  assign rom_off  = addr_i - RomBase;
  assign sram_off = addr_i - SramBase;

  assign in_rom  = (addr_i >= RomBase) && (rom_off < RomBytes);
  assign in_sram = (addr_i >= SramBase) && (sram_off < SramBytes);

  // ROM is read only, so a write there goes to the error responder
  always_comb begin
    if (in_rom && !we_i) begin
      region_o = REGION_ROM;
    end else if (in_sram) begin
      region_o = REGION_SRAM;
    end else begin
      region_o = REGION_ERR;
    end
  end

  assign word_idx_o = in_rom ? rom_off[AddrWidth-1:WordOffset]
                             : sram_off[AddrWidth-1:WordOffset];

  // Strobe only the memory that is legally addressed
  assign rom_req_o  = req_i && (region_o == REGION_ROM);
  assign sram_req_o = req_i && (region_o == REGION_SRAM);
  assign err_o      = req_i && (region_o == REGION_ERR);

endmodule : addr_decode

`default_nettype wire

// File: logic/boot_rom.sv
// Boot ROM model whose words follow a fixed rule, tag above and word index below
`timescale 1ns/1ps
`default_nettype none

module boot_rom import soc_pkg::*; (
  input  logic                            clk_i,
  input  logic                            req_i,
  input  logic [AddrWidth-WordOffset-1:0] word_idx_i,
  output logic [DataWidth-1:0]            rdata_o
);

  // Index bits that address the ROM image
  localparam int unsigned RomIdxWidth = $clog2(RomWords);

  logic [RomIdxWidth-1:0] rom_idx;
  logic [31:0]            idx_word;

  assign rom_idx  = word_idx_i[RomIdxWidth-1:0];
  assign idx_word = 32'(rom_idx);

  // ----------------------------------------------------------
  // Registered read port
  // ----------------------------------------------------------
  always_ff @(posedge clk_i) begin
    if (req_i) begin
      rdata_o <= {RomTag, idx_word};
    end
  end

endmodule : boot_rom

`default_nettype wire

// File: logic/sram_bank.sv
// Single-port SRAM with byte-lane writes and a registered read, backing main memory
`timescale 1ns/1ps
`default_nettype none

module sram_bank import soc_pkg::*; #(
  parameter int unsigned NumWords = 1024
) (
  input  logic                            clk_i,
  input  logic                            req_i,
  input  logic                            we_i,
  input  logic [AddrWidth-WordOffset-1:0] word_idx_i,
  input  logic [StrbWidth-1:0]            be_i,
  input  logic [DataWidth-1:0]            wdata_i,
  output logic [DataWidth-1:0]            rdata_o
);

  localparam int unsigned IdxWidth = (NumWords > 1) ? $clog2(NumWords) : 1;

  logic [DataWidth-1:0] mem_q [NumWords];
  logic [IdxWidth-1:0]  idx;

  // Upper index bits wrap onto the array
  assign idx = word_idx_i[IdxWidth-1:0];

  // ----------------------------------------------------------
  // Write lanes or read word
  // ----------------------------------------------------------
  always_ff @(posedge clk_i) begin
    if (req_i) begin
      if (we_i) begin
        for (int unsigned b = 0; b < StrbWidth; b++) begin
          if (be_i[b]) begin
            mem_q[idx][b*8 +: 8] <= wdata_i[b*8 +: 8];
          end
        end
      end else begin
        rdata_o <= mem_q[idx];
      end
    end
  end

endmodule : sram_bank

`default_nettype wire

// File: logic/resp_mux.sv
// Response stage that tracks the request for one cycle and picks the read data
`timescale 1ns/1ps
`default_nettype none

module resp_mux import soc_pkg::*; (
  input  logic                 clk_i,
  input  logic                 rst_ni,
  input  logic                 req_i,
  input  logic                 we_i,
  input  region_e              region_i,
  input  logic                 err_i,
  input  logic [DataWidth-1:0] rom_rdata_i,
  input  logic [DataWidth-1:0] sram_rdata_i,
  output logic                 rvalid_o,
  output logic [DataWidth-1:0] rdata_o,
  output logic                 err_o
);

  logic    valid_q;
  logic    err_q;
  logic    we_q;
  region_e region_q;

  // Same cycle as the memory access
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      valid_q  <= 1'b0;
      err_q    <= 1'b0;
      we_q     <= 1'b0;
      region_q <= REGION_ERR;
    end else begin
      valid_q  <= req_i;
      err_q    <= err_i;
      we_q     <= req_i & we_i;
      region_q <= region_i;
    end
  end

  // Errors and writes return no data
  always_comb begin
    rdata_o = '0;
    if (!err_q && !we_q) begin
      unique case (region_q)
        REGION_ROM:  rdata_o = rom_rdata_i;
        REGION_SRAM: rdata_o = sram_rdata_i;
        default:     rdata_o = '0;
      endcase
    end
  end

  assign rvalid_o = valid_q;
  assign err_o    = err_q;

endmodule : resp_mux

`default_nettype wire

// File: logic/debug_gate.sv
// Debug request gate that holds requests off after power-on and applies the enable
`timescale 1ns/1ps
`default_nettype none

module debug_gate #(
  parameter int unsigned DmiDelCycles = 500
) (
  input  logic clk_i,
  input  logic rst_ni,
  input  logic debug_enable_i,
  input  logic dm_debug_req_i,
  output logic debug_req_o
);

  localparam int unsigned CntWidth = (DmiDelCycles > 0) ? $clog2(DmiDelCycles + 1) : 1;

  logic [CntWidth-1:0] del_cnt_d;
  logic [CntWidth-1:0] del_cnt_q;
  logic                window_open;

  // ----------------------------------------------------------
  // Post-reset delay window
  // ----------------------------------------------------------

  // Boot code gets to run before the first debug request lands
  assign window_open = (del_cnt_q != '0);
  assign del_cnt_d   = window_open ? del_cnt_q - 1'b1 : '0;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      del_cnt_q <= CntWidth'(DmiDelCycles);
    end else begin
      del_cnt_q <= del_cnt_d;
    end
  end

  // Pass the request once the window has closed
  assign debug_req_o = !window_open && debug_enable_i && dm_debug_req_i;

endmodule : debug_gate

`default_nettype wire

// File: logic/soc_fabric_top.sv
// Top of the memory fabric, tying reset, decode, memories, response and debug gate together
`timescale 1ns/1ps
`default_nettype none

module soc_fabric_top import soc_pkg::*; #(
  parameter int unsigned NumWords     = 1024,
  parameter int unsigned DmiDelCycles = 500
) (
  input  logic                 clk_i,
  input  logic                 rst_ni,
  input  logic                 ndmreset_i,
  input  logic                 req_i,
  input  logic                 we_i,
  input  logic [AddrWidth-1:0] addr_i,
  input  logic [StrbWidth-1:0] be_i,
  input  logic [DataWidth-1:0] wdata_i,
  output logic                 rvalid_o,
  output logic [DataWidth-1:0] rdata_o,
  output logic                 err_o,
  input  logic                 debug_enable_i,
  input  logic                 dm_debug_req_i,
  output logic                 debug_req_o
);

  logic                            sys_rst_n;
  region_e                         region;
  logic                            rom_req;
  logic                            sram_req;
  logic [AddrWidth-WordOffset-1:0] word_idx;
  logic                            dec_err;
  logic [DataWidth-1:0]            rom_rdata;
  logic [DataWidth-1:0]            sram_rdata;

  // ----------------------------------------------------------
  // Reset
  // ----------------------------------------------------------
  reset_sync i_reset_sync (
    .clk_i      ( clk_i      ),
    .rst_ni     ( rst_ni     ),
    .ndmreset_i ( ndmreset_i ),
    .sys_rst_no ( sys_rst_n  )
  );

  // ----------------------------------------------------------
  // Decode and memories
  // ----------------------------------------------------------
  addr_decode #(
    .NumWords ( NumWords )
  ) i_addr_decode (
    .req_i      ( req_i    ),
    .we_i       ( we_i     ),
    .addr_i     ( addr_i   ),
    .region_o   ( region   ),
    .rom_req_o  ( rom_req  ),
    .sram_req_o ( sram_req ),
    .word_idx_o ( word_idx ),
    .err_o      ( dec_err  )
  );

  boot_rom i_boot_rom (
    .clk_i      ( clk_i     ),
    .req_i      ( rom_req   ),
    .word_idx_i ( word_idx  ),
    .rdata_o    ( rom_rdata )
  );

  sram_bank #(
    .NumWords ( NumWords )
  ) i_sram_bank (
    .clk_i      ( clk_i      ),
    .req_i      ( sram_req   ),
    .we_i       ( we_i       ),
    .word_idx_i ( word_idx   ),
    .be_i       ( be_i       ),
    .wdata_i    ( wdata_i    ),
    .rdata_o    ( sram_rdata )
  );

  resp_mux i_resp_mux (
    .clk_i        ( clk_i      ),
    .rst_ni       ( sys_rst_n  ),
    .req_i        ( req_i      ),
    .we_i         ( we_i       ),
    .region_i     ( region     ),
    .err_i        ( dec_err    ),
    .rom_rdata_i  ( rom_rdata  ),
    .sram_rdata_i ( sram_rdata ),
    .rvalid_o     ( rvalid_o   ),
    .rdata_o      ( rdata_o    ),
    .err_o        ( err_o      )
  );

  // ----------------------------------------------------------
  // Debug request, on power-on reset only
  // ----------------------------------------------------------
  debug_gate #(
    .DmiDelCycles ( DmiDelCycles )
  ) i_debug_gate (
    .clk_i          ( clk_i          ),
    .rst_ni         ( rst_ni         ),
    .debug_enable_i ( debug_enable_i ),
    .dm_debug_req_i ( dm_debug_req_i ),
    .debug_req_o    ( debug_req_o    )
  );

endmodule : soc_fabric_top

`default_nettype wire

// File: dv/tb_soc_checks.svh
// Reference model of the fabric, with shadow SRAM and compare task, included by the testbench
`ifndef TB_SOC_CHECKS_SVH
`define TB_SOC_CHECKS_SVH

// Shadow copy of the SRAM, merged lane by lane
logic [DataWidth-1:0] shadow_mem [NumWords];

// ------------------------------------------------------------
// Reference functions
// ------------------------------------------------------------
function automatic logic [DataWidth-1:0] rom_word(input logic [AddrWidth-1:0] idx);
  rom_word = {RomTag, idx};
endfunction

function automatic region_e classify(input logic [AddrWidth-1:0] a, input logic wr);
  logic [AddrWidth-1:0] rom_end;
  logic [AddrWidth-1:0] sram_end;
  rom_end  = RomBase + AddrWidth'(RomWords * 8);
  sram_end = SramBase + AddrWidth'(NumWords * 8);
  // ROM writes land in the error responder
  if (a >= RomBase && a < rom_end && !wr) begin
    classify = REGION_ROM;
  end else if (a >= SramBase && a < sram_end) begin
    classify = REGION_SRAM;
  end else begin
    classify = REGION_ERR;
  end
endfunction

function automatic logic exp_err(input logic [AddrWidth-1:0] a, input logic wr);
  exp_err = (classify(a, wr) == REGION_ERR);
endfunction

function automatic logic [DataWidth-1:0] exp_rdata(input logic [AddrWidth-1:0] a,
                                                   input logic wr);
  region_e              r;
  logic [AddrWidth-1:0] idx;
  r         = classify(a, wr);
  exp_rdata = '0;
  if (r == REGION_ROM && !wr) begin
    idx       = (a - RomBase) >> WordOffset;
    exp_rdata = rom_word(idx);
  end else if (r == REGION_SRAM && !wr) begin
    idx       = (a - SramBase) >> WordOffset;
    exp_rdata = shadow_mem[idx[SramIdxW-1:0]];
  end
endfunction

task automatic shadow_write(input logic [AddrWidth-1:0] a, input logic [StrbWidth-1:0] strb,
                            input logic [DataWidth-1:0] d);
  logic [AddrWidth-1:0] idx;
  idx = (a - SramBase) >> WordOffset;
  for (int b = 0; b < StrbWidth; b++) begin
    if (strb[b]) begin
      shadow_mem[idx[SramIdxW-1:0]][b*8 +: 8] = d[b*8 +: 8];
    end
  end
endtask

// ------------------------------------------------------------
// Compare
// ------------------------------------------------------------
task automatic check_equal(input logic [DataWidth-1:0] got, input logic [DataWidth-1:0] exp,
                           input string what);
  num_checks++;
  if (got !== exp) begin
    num_errors++;
    $display("ERROR at %0t: %s, got %h, expected %h", $time, what, got, exp);
  end
endtask

`endif

// File: dv/tb_soc_fabric.sv
// Testbench for the fabric top, drives requests, resets and debug inputs, checks every response
`timescale 1ns/1ps
`default_nettype none

module tb_soc_fabric import soc_pkg::*; ();

  localparam int unsigned NumWords     = 256;
  localparam int unsigned DmiDelCycles = 20;
  localparam int unsigned SramIdxW     = $clog2(NumWords);

  logic                 clk;
  logic                 rst_n;
  logic                 ndmreset;
  logic                 req;
  logic                 we;
  logic [AddrWidth-1:0] addr;
  logic [StrbWidth-1:0] be;
  logic [DataWidth-1:0] wdata;
  logic                 rvalid;
  logic [DataWidth-1:0] rdata;
  logic                 err;
  logic                 debug_enable;
  logic                 dm_debug_req;
  logic                 debug_req;

  integer               seed;
  logic [31:0]          rnd;
  int                   num_checks;
  int                   num_errors;
  logic                 chk_en;
  logic [DataWidth-1:0] cur_data;
  logic                 cur_err;
  logic [AddrWidth-1:0] cur_addr;
  logic                 pend_valid;
  logic [DataWidth-1:0] pend_data;
  logic                 pend_err;
  logic [AddrWidth-1:0] pend_addr;

  `include "tb_soc_checks.svh"

  soc_fabric_top #(
    .NumWords     ( NumWords     ),
    .DmiDelCycles ( DmiDelCycles )
  ) uut (
    .clk_i          ( clk          ),
    .rst_ni         ( rst_n        ),
    .ndmreset_i     ( ndmreset     ),
    .req_i          ( req          ),
    .we_i           ( we           ),
    .addr_i         ( addr         ),
    .be_i           ( be           ),
    .wdata_i        ( wdata        ),
    .rvalid_o       ( rvalid       ),
    .rdata_o        ( rdata        ),
    .err_o          ( err          ),
    .debug_enable_i ( debug_enable ),
    .dm_debug_req_i ( dm_debug_req ),
    .debug_req_o    ( debug_req    )
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  // ------------------------------------------------------------
  // Request driver and response checker
  // ------------------------------------------------------------
  task automatic issue(input logic wr, input logic [AddrWidth-1:0] a,
                       input logic [StrbWidth-1:0] strb, input logic [DataWidth-1:0] d);
    @(posedge clk);
    req      <= 1'b1;
    we       <= wr;
    addr     <= a;
    be       <= strb;
    wdata    <= d;
    cur_addr = a;
    cur_data = exp_rdata(a, wr);
    cur_err  = exp_err(a, wr);
    if (wr && classify(a, wr) == REGION_SRAM) begin
      shadow_write(a, strb, d);
    end
  endtask

  task automatic idle();
    @(posedge clk);
    req <= 1'b0;
    we  <= 1'b0;
  endtask

  task automatic end_test(input string name, input int err_start);
    idle();
    idle();
    $display("Test %s done with %0d errors", name, num_errors - err_start);
  endtask

  // Response shows one cycle after the request
  always @(negedge clk) begin
    if (chk_en) begin
      check_equal(DataWidth'(rvalid), DataWidth'(pend_valid), "rvalid");
      if (pend_valid) begin
        check_equal(rdata, pend_data, $sformatf("rdata at %h", pend_addr));
        check_equal(DataWidth'(err), DataWidth'(pend_err), $sformatf("err at %h", pend_addr));
      end
    end
    pend_valid = req;
    pend_data  = cur_data;
    pend_err   = cur_err;
    pend_addr  = cur_addr;
  end

  // ------------------------------------------------------------
  // Test sequence
  // ------------------------------------------------------------
  initial begin
    int                   err_start;
    int                   low_cnt;
    logic                 seen;
    logic [AddrWidth-1:0] a;
    logic [AddrWidth-1:0] bad_addr [6];
    seed         = 30;
    rst_n        = 1'b0;
    ndmreset     = 1'b0;
    req          = 1'b0;
    we           = 1'b0;
    addr         = '0;
    be           = '0;
    wdata        = '0;
    debug_enable = 1'b1;
    dm_debug_req = 1'b1;
    chk_en       = 1'b0;
    num_checks   = 0;
    num_errors   = 0;
    cur_data     = '0;
    cur_err      = 1'b0;
    cur_addr     = '0;
    repeat (8) @(posedge clk);
    rst_n <= 1'b1;

    // Debug window after power-on reset
    err_start = num_errors;
    low_cnt   = 0;
    seen      = 1'b0;
    for (int n = 0; n < int'(DmiDelCycles) + 50 && !seen; n++) begin
      @(negedge clk);
      if (debug_req) begin
        seen = 1'b1;
      end else begin
        low_cnt++;
      end
    end
    if (!seen) begin
      num_errors++;
      $display("Timeout: debug request never reached the core after power-on reset");
    end
    check_equal(DataWidth'(low_cnt), DataWidth'(DmiDelCycles), "debug window length");
    @(posedge clk);
    debug_enable <= 1'b0;
    @(negedge clk);
    check_equal(DataWidth'(debug_req), '0, "debug_req with enable low");
    @(posedge clk);
    debug_enable <= 1'b1;
    @(negedge clk);
    check_equal(DataWidth'(debug_req), DataWidth'(1), "debug_req with enable high");
    idle();
    chk_en = 1'b1;
    end_test("debug_gate", err_start);

    // Random ROM reads
    err_start = num_errors;
    for (int i = 0; i < 24; i++) begin
      rnd = $random(seed);
      issue(1'b0, RomBase + AddrWidth'({rnd[8:0], 3'b000}), rnd[15:8], '0);
    end
    end_test("rom_read", err_start);

    // Fill words, merge random lanes, read back to back
    err_start = num_errors;
    for (int i = 0; i < 32; i++) begin
      issue(1'b1, SramBase + AddrWidth'(i * 8), 8'hFF, {$random(seed), $random(seed)});
    end
    for (int i = 0; i < 48; i++) begin
      rnd = $random(seed);
      a   = SramBase + AddrWidth'({rnd[4:0], 3'b000});
      issue(1'b1, a, rnd[15:8], {$random(seed), $random(seed)});
      issue(1'b0, a, 8'hFF, '0);
    end
    for (int i = 0; i < 32; i++) begin
      issue(1'b0, SramBase + AddrWidth'(i * 8), 8'hFF, '0);
    end
    end_test("sram_rw", err_start);

    // Unmapped space and ROM writes
    err_start = num_errors;
    bad_addr  = '{32'h0, RomBase - 32'd8, RomBase + AddrWidth'(RomWords * 8),
                  32'h4000_0000, SramBase + AddrWidth'(NumWords * 8), 32'hFFFF_FFF8};
    for (int i = 0; i < 6; i++) begin
      rnd = $random(seed);
      issue(rnd[0], bad_addr[i], 8'hFF, {$random(seed), $random(seed)});
    end
    for (int i = 0; i < 8; i++) begin
      rnd = $random(seed);
      issue(1'b1, RomBase + AddrWidth'({rnd[8:0], 3'b000}), rnd[15:8], {rnd, rnd});
    end
    issue(1'b0, SramBase + 32'd24, 8'hFF, '0);
    end_test("error_space", err_start);

    // Requests with random gaps
    err_start = num_errors;
    for (int i = 0; i < 40; i++) begin
      rnd = $random(seed);
      if (rnd[0]) begin
        issue(1'b0, SramBase + AddrWidth'({rnd[5:1], 3'b000}), 8'hFF, '0);
      end else begin
        idle();
      end
    end
    end_test("rvalid_timing", err_start);

    // Non-debug reset pulse
    err_start = num_errors;
    chk_en    = 1'b0;
    issue(1'b0, SramBase + 32'd8, 8'hFF, '0);
    ndmreset <= 1'b1;
    for (int i = 0; i < 4; i++) begin
      @(negedge clk);
      check_equal(DataWidth'(rvalid), '0, "rvalid during ndmreset");
      check_equal(DataWidth'(debug_req), DataWidth'(1), "debug_req during ndmreset");
      issue(1'b0, SramBase + 32'd8, 8'hFF, '0);
    end
    ndmreset <= 1'b0;
    seen = 1'b0;
    for (int n = 0; n < 10 && !seen; n++) begin
      @(negedge clk);
      if (rvalid) begin
        seen = 1'b1;
        check_equal(rdata, exp_rdata(SramBase + 32'd8, 1'b0), "first read after ndmreset");
      end else begin
        issue(1'b0, SramBase + 32'd8, 8'hFF, '0);
      end
    end
    if (!seen) begin
      num_errors++;
      $display("Timeout: no response came back after ndmreset was released");
    end
    idle();
    idle();
    chk_en = 1'b1;
    for (int i = 0; i < 32; i++) begin
      issue(1'b0, SramBase + AddrWidth'(i * 8), 8'hFF, '0);
    end
    end_test("ndmreset", err_start);

    $display("Checks run: %0d, errors: %0d", num_checks, num_errors);
    if (num_errors == 0) begin
      $display("TEST PASS");
    end else begin
      $display("TEST FAIL");
    end
    $finish;
  end

endmodule : tb_soc_fabric

`default_nettype wire

// File: sources.f
+incdir+dv
logic/soc_pkg.sv
logic/reset_sync.sv
logic/addr_decode.sv
logic/boot_rom.sv
logic/sram_bank.sv
logic/resp_mux.sv
logic/debug_gate.sv
logic/soc_fabric_top.sv
dv/tb_soc_fabric.sv

// File: Makefile
# Verilator lint and simulation of the memory fabric testbench

TOP := tb_soc_fabric

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing -f sources.f --top-module $(TOP)

sim:
	verilator --binary --timing -Wno-fatal -f sources.f --top-module $(TOP) -o sim_$(TOP)
	./obj_dir/sim_$(TOP) > sim.log 2>&1 ; cat sim.log
	grep -q "^TEST PASS$$" sim.log

clean:
	rm -rf obj_dir sim.log
